//--- design/ddr_accel_pkg.sv
// shared widths, memory command and lane payload types for the accelerator; compile first
`default_nettype none

package ddr_accel_pkg;

  // ---------------------------------------------------------------------
  // memory geometry
  // ---------------------------------------------------------------------
  // one word holds four 16-bit elements
  parameter int data_width = 64;
  parameter int addr_width = 10;
  // burst length field, words minus one
  parameter int len_width  = 8;

  // start of the result region in word addresses
  parameter logic [addr_width-1:0] result_base = 10'h100;

  // ---------------------------------------------------------------------
  // memory command channel
  // ---------------------------------------------------------------------
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e               op;
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
  } mem_cmd_t;

  // ---------------------------------------------------------------------
  // lane payloads
  // ---------------------------------------------------------------------
  // e0 sits in the low 16 bits of the memory word
  typedef struct packed {
    logic [15:0] e3;
    logic [15:0] e2;
    logic [15:0] e1;
    logic [15:0] e0;
  } lane_beat_t;

  typedef struct packed {
    logic [31:0] sum;
  } lane_result_t;

endpackage

`default_nettype wire

//--- design/mem_model.sv
// on-chip burst memory standing in for the DDR3 controller command and data channels
`timescale 1ns/1ns
`default_nettype none

module mem_model (
  input  wire logic                                 clk_40M,
  input  wire logic                                 rst_n,
  input  wire ddr_accel_pkg::mem_cmd_t              cmd,
  input  wire logic                                 cmd_valid,
  output logic                                      cmd_ready,
  input  wire logic [ddr_accel_pkg::data_width-1:0] wr_data,
  input  wire logic                                 wr_valid,
  output logic                                      wr_ready,
  output logic      [ddr_accel_pkg::data_width-1:0] rd_data,
  output logic                                      rd_valid,
  output logic                                      mem_done,
  input  wire logic [ddr_accel_pkg::addr_width-1:0] host_addr,
  output logic      [ddr_accel_pkg::data_width-1:0] host_data
);

  localparam int DEPTH = 1 << ddr_accel_pkg::addr_width;

  typedef enum logic [1:0] {
    m_idle,
    m_write,
    m_read
  } mem_state_e;

  mem_state_e                              state;
  ddr_accel_pkg::mem_cmd_t                 cur;
  logic [ddr_accel_pkg::len_width-1:0]     cnt;
  logic [ddr_accel_pkg::addr_width-1:0]    word_addr;
  logic [ddr_accel_pkg::data_width-1:0]    mem [DEPTH];

  assign cmd_ready = (state == m_idle);
  assign wr_ready  = (state == m_write);
  assign word_addr = cur.addr + ddr_accel_pkg::addr_width'(cnt);
  assign host_data = mem[host_addr];

  // burst sequencing, one word per cycle
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state    <= m_idle;
      cnt      <= '0;
      rd_valid <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      mem_done <= 1'b0;
      case (state)
        m_idle: begin
          cnt <= '0;
          if (cmd_valid) begin
            state <= (cmd.op == ddr_accel_pkg::op_write) ? m_write : m_read;
          end
        end
        m_write: begin
          if (wr_valid) begin
            cnt <= cnt + 1'b1;
            if (cnt == cur.len) begin
              state    <= m_idle;
              mem_done <= 1'b1;
            end
          end
        end
        m_read: begin
          // data lands one cycle later, two after the command
          rd_valid <= 1'b1;
          cnt      <= cnt + 1'b1;
          if (cnt == cur.len) begin
            state    <= m_idle;
            mem_done <= 1'b1;
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

  // array and data path
  always_ff @(posedge clk_40M) begin
    if (state == m_idle && cmd_valid) cur <= cmd;
    if (state == m_write && wr_valid) mem[word_addr] <= wr_data;
    if (state == m_read) rd_data <= mem[word_addr];
  end

endmodule

`default_nettype wire

//--- design/init_loader.sv
// writes the seeded test pattern into the data region as one burst before compute starts
`timescale 1ns/1ns
`default_nettype none

module init_loader #(
  parameter int NUM_LANES      = 4,
  parameter int BEATS_PER_LANE = 8
) (
  input  wire logic                                 clk_40M,
  input  wire logic                                 rst_n,
  input  wire logic                                 start,
  input  wire logic [15:0]                          pattern_seed,
  output ddr_accel_pkg::mem_cmd_t                   cmd,
  output logic                                      cmd_valid,
  input  wire logic                                 cmd_ready,
  output logic      [ddr_accel_pkg::data_width-1:0] wr_data,
  output logic                                      wr_valid,
  input  wire logic                                 wr_ready,
  output logic                                      init_done
);

  localparam int WORDS = NUM_LANES * BEATS_PER_LANE;
  localparam int LW    = ddr_accel_pkg::len_width;

  typedef enum logic [1:0] {
    ld_idle,
    ld_cmd,
    ld_data,
    ld_done
  } ld_state_e;

  ld_state_e       state;
  logic [LW-1:0]   word_cnt;

  assign cmd       = '{op: ddr_accel_pkg::op_write, addr: '0, len: LW'(WORDS - 1)};
  assign cmd_valid = (state == ld_cmd);
  assign wr_valid  = (state == ld_data);
  assign init_done = (state == ld_done);

  // element j of word i is seed + 4i + j, kept to 8 bits
  for (genvar j = 0; j < 4; j++) begin : g_elem
    assign wr_data[16*j +: 16] =
      {8'h00, 8'(pattern_seed[7:0] + {word_cnt[5:0], 2'b00} + 8'(j))};
  end

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ld_idle;
      word_cnt <= '0;
    end else begin
      case (state)
        ld_idle: if (start) state <= ld_cmd;
        ld_cmd:  if (cmd_ready) state <= ld_data;
        ld_data: begin
          if (wr_ready) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == LW'(WORDS - 1)) state <= ld_done;
          end
        end
        default: state <= ld_done;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/conv_feeder.sv
// reads the data region back and deals each beat to the lanes in turn
`timescale 1ns/1ns
`default_nettype none

module conv_feeder #(
  parameter int NUM_LANES      = 4,
  parameter int BEATS_PER_LANE = 8
) (
  input  wire logic                                 clk_40M,
  input  wire logic                                 rst_n,
  input  wire logic                                 init_done,
  output ddr_accel_pkg::mem_cmd_t                   cmd,
  output logic                                      cmd_valid,
  input  wire logic                                 cmd_ready,
  input  wire logic [ddr_accel_pkg::data_width-1:0] rd_data,
  input  wire logic                                 rd_valid,
  output ddr_accel_pkg::lane_beat_t                 beat,
  output logic      [NUM_LANES-1:0]                 beat_valid,
  output logic                                      reads_done
);

  localparam int WORDS = NUM_LANES * BEATS_PER_LANE;
  localparam int LW    = ddr_accel_pkg::len_width;

  typedef enum logic [1:0] {
    fd_idle,
    fd_cmd,
    fd_recv,
    fd_done
  } fd_state_e;

  fd_state_e              state;
  logic [LW-1:0]          beat_cnt;
  // one-hot lane pointer
  logic [NUM_LANES-1:0]   lane_sel;

  assign cmd        = '{op: ddr_accel_pkg::op_read, addr: '0, len: LW'(WORDS - 1)};
  assign cmd_valid  = (state == fd_cmd);
  assign reads_done = (state == fd_done);

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state      <= fd_idle;
      beat_cnt   <= '0;
      lane_sel   <= NUM_LANES'(1);
      beat_valid <= '0;
    end else begin
      beat_valid <= '0;
      case (state)
        fd_idle: if (init_done) state <= fd_cmd;
        fd_cmd:  if (cmd_ready) state <= fd_recv;
        fd_recv: begin
          // no back-pressure on the read stream, take every beat
          if (rd_valid) begin
            beat_valid <= lane_sel;
            lane_sel   <= (lane_sel << 1) | (lane_sel >> (NUM_LANES - 1));
            beat_cnt   <= beat_cnt + 1'b1;
            if (beat_cnt == LW'(WORDS - 1)) state <= fd_done;
          end
        end
        default: state <= fd_done;
      endcase
    end
  end

  // beat payload shared by all lanes
  always_ff @(posedge clk_40M) begin
    if (rd_valid) beat <= rd_data;
  end

endmodule

`default_nettype wire

//--- design/mac_lane.sv
// one multiply-accumulate lane: sums e0*e1 + e2*e3 over its beats, then offers the result
`timescale 1ns/1ns
`default_nettype none

module mac_lane #(
  parameter int BEATS_PER_LANE = 8
) (
  input  wire logic                        clk_40M,
  input  wire logic                        rst_n,
  input  wire ddr_accel_pkg::lane_beat_t   beat,
  input  wire logic                        beat_valid,
  output ddr_accel_pkg::lane_result_t      res,
  output logic                             res_valid,
  input  wire logic                        res_ready
);

  localparam int CNT_W = $clog2(BEATS_PER_LANE + 1);

  logic [31:0]       acc;
  logic [31:0]       prod_lo, prod_hi;
  logic [CNT_W-1:0]  beat_cnt;

  assign prod_lo = beat.e0 * beat.e1;
  assign prod_hi = beat.e2 * beat.e3;
  assign res     = '{sum: acc};

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      acc       <= '0;
      beat_cnt  <= '0;
      res_valid <= 1'b0;
    end else if (res_valid) begin
      // hold the sum until the writer takes it
      if (res_ready) begin
        res_valid <= 1'b0;
        acc       <= '0;
        beat_cnt  <= '0;
      end
    end else if (beat_valid) begin
      acc <= acc + prod_lo + prod_hi;
      if (beat_cnt == CNT_W'(BEATS_PER_LANE - 1)) begin
        res_valid <= 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/result_writer.sv
// collects lane sums in lane order and writes them to the result region, then flags done
`timescale 1ns/1ns
`default_nettype none

module result_writer #(
  parameter int NUM_LANES = 4
) (
  input  wire logic                                         clk_40M,
  input  wire logic                                         rst_n,
  input  wire ddr_accel_pkg::lane_result_t [NUM_LANES-1:0]  res,
  input  wire logic [NUM_LANES-1:0]                         res_valid,
  output logic      [NUM_LANES-1:0]                         res_ready,
  output ddr_accel_pkg::mem_cmd_t                           cmd,
  output logic                                              cmd_valid,
  input  wire logic                                         cmd_ready,
  output logic      [ddr_accel_pkg::data_width-1:0]         wr_data,
  output logic                                              wr_valid,
  input  wire logic                                         wr_ready,
  input  wire logic                                         mem_done,
  output logic                                              done
);

  localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  typedef enum logic [2:0] {
    rw_collect,
    rw_cmd,
    rw_data,
    rw_wait,
    rw_finished
  } rw_state_e;

  rw_state_e         state;
  logic [IDX_W-1:0]  idx;
  logic [31:0]       sums [NUM_LANES];

  assign cmd = '{op: ddr_accel_pkg::op_write, addr: ddr_accel_pkg::result_base,
                 len: ddr_accel_pkg::len_width'(NUM_LANES - 1)};
  assign cmd_valid = (state == rw_cmd);
  assign wr_valid  = (state == rw_data);
  assign wr_data   = {32'h0, sums[idx]};
  assign done      = (state == rw_finished);

  // only the lane whose turn it is sees ready
  always_comb begin
    res_ready = '0;
    if (state == rw_collect) res_ready[idx] = 1'b1;
  end

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state <= rw_collect;
      idx   <= '0;
    end else begin
      case (state)
        rw_collect: begin
          if (res_valid[idx]) begin
            idx <= (idx == IDX_W'(NUM_LANES - 1)) ? '0 : idx + 1'b1;
            if (idx == IDX_W'(NUM_LANES - 1)) state <= rw_cmd;
          end
        end
        rw_cmd: if (cmd_ready) state <= rw_data;
        rw_data: begin
          if (wr_ready) begin
            idx <= idx + 1'b1;
            if (idx == IDX_W'(NUM_LANES - 1)) state <= rw_wait;
          end
        end
        // burst end from the memory
        rw_wait: if (mem_done) state <= rw_finished;
        default: state <= rw_finished;
      endcase
    end
  end

  always_ff @(posedge clk_40M) begin
    if (state == rw_collect && res_valid[idx]) sums[idx] <= res[idx].sum;
  end

endmodule

`default_nettype wire

//--- design/ddr_accel_top.sv
// top level of the accelerator: reset hold, phase control and sharing of the one memory port
`timescale 1ns/1ns
`default_nettype none

module ddr_accel_top #(
  parameter int NUM_LANES      = 4,
  parameter int BEATS_PER_LANE = 8,
  parameter int RST_CNT        = 16
) (
  input  wire logic                                   clk_40M,
  input  wire logic                                   clk_40MHz_locked,
  input  wire logic                                   start,
  input  wire logic [15:0]                            pattern_seed,
  input  wire logic [ddr_accel_pkg::addr_width-1:0]   host_addr,
  output logic      [ddr_accel_pkg::data_width-1:0]   host_data,
  output logic                                        done
);

  localparam int CNT_W = $clog2(RST_CNT + 1);

  typedef enum logic [1:0] {
    ph_load,
    ph_compute,
    ph_writeback
  } phase_e;

  logic             rst_n;
  logic [CNT_W-1:0] rst_cnt;
  phase_e           phase;

  // shared memory port
  ddr_accel_pkg::mem_cmd_t              mem_cmd;
  logic                                 mem_cmd_valid, mem_cmd_ready;
  logic [ddr_accel_pkg::data_width-1:0] mem_wr_data, mem_rd_data;
  logic                                 mem_wr_valid, mem_wr_ready;
  logic                                 mem_rd_valid, mem_done;

  // per client channels
  ddr_accel_pkg::mem_cmd_t              ld_cmd, fd_cmd, rw_cmd;
  logic                                 ld_cmd_valid, fd_cmd_valid, rw_cmd_valid;
  logic                                 ld_cmd_ready, fd_cmd_ready, rw_cmd_ready;
  logic [ddr_accel_pkg::data_width-1:0] ld_wr_data, rw_wr_data;
  logic                                 ld_wr_valid, rw_wr_valid;
  logic                                 ld_wr_ready, rw_wr_ready;
  logic                                 init_done, reads_done;

  ddr_accel_pkg::lane_beat_t                      lane_beat;
  logic [NUM_LANES-1:0]                           beat_valid;
  ddr_accel_pkg::lane_result_t [NUM_LANES-1:0]    lane_res;
  logic [NUM_LANES-1:0]                           res_valid, res_ready;

  // ---------------------------------------------------------------------
  // reset hold after clock lock
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_cnt <= '0;
      rst_n   <= 1'b0;
    end else if (!rst_n) begin
      if (rst_cnt == CNT_W'(RST_CNT - 1)) begin
        rst_n <= 1'b1;
      end else begin
        rst_cnt <= rst_cnt + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // phase register and port ownership
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      phase <= ph_load;
    end else begin
      case (phase)
        ph_load:    if (init_done) phase <= ph_compute;
        ph_compute: if (reads_done) phase <= ph_writeback;
        default:    phase <= phase;
      endcase
    end
  end

  // loader drives the port by default
  always_comb begin
    mem_cmd       = ld_cmd;
    mem_cmd_valid = ld_cmd_valid;
    mem_wr_data   = ld_wr_data;
    mem_wr_valid  = ld_wr_valid;
    case (phase)
      ph_compute: begin
        mem_cmd       = fd_cmd;
        mem_cmd_valid = fd_cmd_valid;
        mem_wr_valid  = 1'b0;
      end
      ph_writeback: begin
        mem_cmd       = rw_cmd;
        mem_cmd_valid = rw_cmd_valid;
        mem_wr_data   = rw_wr_data;
        mem_wr_valid  = rw_wr_valid;
      end
      default: ;
    endcase
  end

  // readies only reach the current owner
  assign ld_cmd_ready = (phase == ph_load) && mem_cmd_ready;
  assign ld_wr_ready  = (phase == ph_load) && mem_wr_ready;
  assign fd_cmd_ready = (phase == ph_compute) && mem_cmd_ready;
  assign rw_cmd_ready = (phase == ph_writeback) && mem_cmd_ready;
  assign rw_wr_ready  = (phase == ph_writeback) && mem_wr_ready;

  // ---------------------------------------------------------------------
  // blocks
  // ---------------------------------------------------------------------
  mem_model u_mem (
    .clk_40M, .rst_n,
    .cmd(mem_cmd), .cmd_valid(mem_cmd_valid), .cmd_ready(mem_cmd_ready),
    .wr_data(mem_wr_data), .wr_valid(mem_wr_valid), .wr_ready(mem_wr_ready),
    .rd_data(mem_rd_data), .rd_valid(mem_rd_valid), .mem_done,
    .host_addr, .host_data
  );

  init_loader #(.NUM_LANES(NUM_LANES), .BEATS_PER_LANE(BEATS_PER_LANE)) u_loader (
    .clk_40M, .rst_n, .start, .pattern_seed,
    .cmd(ld_cmd), .cmd_valid(ld_cmd_valid), .cmd_ready(ld_cmd_ready),
    .wr_data(ld_wr_data), .wr_valid(ld_wr_valid), .wr_ready(ld_wr_ready),
    .init_done
  );

  conv_feeder #(.NUM_LANES(NUM_LANES), .BEATS_PER_LANE(BEATS_PER_LANE)) u_feeder (
    .clk_40M, .rst_n, .init_done,
    .cmd(fd_cmd), .cmd_valid(fd_cmd_valid), .cmd_ready(fd_cmd_ready),
    .rd_data(mem_rd_data), .rd_valid(mem_rd_valid),
    .beat(lane_beat), .beat_valid, .reads_done
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    mac_lane #(.BEATS_PER_LANE(BEATS_PER_LANE)) u_lane (
      .clk_40M, .rst_n,
      .beat(lane_beat), .beat_valid(beat_valid[k]),
      .res(lane_res[k]), .res_valid(res_valid[k]), .res_ready(res_ready[k])
    );
  end

  result_writer #(.NUM_LANES(NUM_LANES)) u_writer (
    .clk_40M, .rst_n,
    .res(lane_res), .res_valid, .res_ready,
    .cmd(rw_cmd), .cmd_valid(rw_cmd_valid), .cmd_ready(rw_cmd_ready),
    .wr_data(rw_wr_data), .wr_valid(rw_wr_valid), .wr_ready(rw_wr_ready),
    .mem_done, .done
  );

endmodule

`default_nettype wire

//--- verification/tb_ddr_accel.sv
// testbench for ddr_accel_top: runs a table of seeds, then reads memory back over the host port
`timescale 1ns/1ns
`default_nettype none

module tb_ddr_accel;

  localparam int NUM_LANES       = 4;
  localparam int BEATS_PER_LANE  = 8;
  localparam int RST_CNT         = 16;
  localparam int WORDS           = NUM_LANES * BEATS_PER_LANE;
  localparam int CLK_PERIOD      = 100;
  localparam int ROWS            = 5;
  localparam int DONE_LIMIT      = 200;
  localparam int WATCHDOG_CYCLES = ROWS * (RST_CNT + 200);

  // zero in exp_lane0 means lane 0 is derived from the model as well
  typedef struct packed {
    logic [15:0] seed;
    logic [31:0] exp_lane0;
  } vector_t;

  logic                                 clk_40M;
  logic                                 clk_40MHz_locked;
  logic                                 start;
  logic [15:0]                          pattern_seed;
  logic [ddr_accel_pkg::addr_width-1:0] host_addr;
  logic [ddr_accel_pkg::data_width-1:0] host_data;
  logic                                 done;

  vector_t     vectors [ROWS];
  logic [31:0] rnd;
  logic        done_q;
  int          done_rises = 0;
  int          mismatches = 0;
  int          failures   = 0;

  ddr_accel_top #(
    .NUM_LANES(NUM_LANES),
    .BEATS_PER_LANE(BEATS_PER_LANE),
    .RST_CNT(RST_CNT)
  ) DUT (
    .clk_40M, .clk_40MHz_locked, .start, .pattern_seed,
    .host_addr, .host_data, .done
  );

  always #(CLK_PERIOD / 2) clk_40M = ~clk_40M;

  // count rising edges of done over the whole run
  always @(posedge clk_40M) begin
    if (done === 1'b1 && done_q !== 1'b1) done_rises <= done_rises + 1;
    done_q <= done;
  end

  // ----------------------------------------------------------------------
  // reference model of the loader pattern and the lane sums
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // element j of word i, wrapped to 8 bits
  function automatic logic [15:0] elem_value(input logic [15:0] seed, input int word,
                                             input int j);
    logic [7:0] v;
    v = seed[7:0] + 8'(4 * word + j);
    return {8'h00, v};
  endfunction

  function automatic logic [63:0] word_value(input logic [15:0] seed, input int word);
    logic [63:0] w;
    for (int j = 0; j < 4; j++) begin
      w[16*j +: 16] = elem_value(seed, word, j);
    end
    return w;
  endfunction

  // lane k sees words k, k+NUM_LANES, ...
  function automatic logic [31:0] lane_sum(input logic [15:0] seed, input int lane);
    logic [31:0] acc;
    int          i;
    acc = '0;
    for (int b = 0; b < BEATS_PER_LANE; b++) begin
      i   = lane + b * NUM_LANES;
      acc = acc + 32'(elem_value(seed, i, 0)) * 32'(elem_value(seed, i, 1))
                + 32'(elem_value(seed, i, 2)) * 32'(elem_value(seed, i, 3));
    end
    return acc;
  endfunction

  // ----------------------------------------------------------------------
  // one table row: reset, start, wait for done, read back
  // ----------------------------------------------------------------------
  task automatic check_host_word(input int r, input int addr, input logic [63:0] expv);
    @(posedge clk_40M);
    host_addr <= ddr_accel_pkg::addr_width'(addr);
    @(negedge clk_40M);
    if (host_data !== expv) begin
      mismatches++;
      $display("mismatch at %0t ns: row %0d addr %03h read %h expected %h",
               $time, r, addr, host_data, expv);
    end
    if (done !== 1'b1) begin
      mismatches++;
      $display("mismatch at %0t ns: row %0d done fell during readback", $time, r);
    end
  endtask

  task automatic run_row(input int r);
    logic [15:0] seed;
    logic [31:0] sum;
    int          waited;
    int          rises_before;
    seed = vectors[r].seed;
    @(posedge clk_40M);
    clk_40MHz_locked <= 1'b0;
    start            <= 1'b0;
    pattern_seed     <= seed;
    host_addr        <= '0;
    repeat (10) @(posedge clk_40M);
    clk_40MHz_locked <= 1'b1;
    repeat (RST_CNT + 2) @(posedge clk_40M);
    rises_before = done_rises;
    // nothing may happen before start
    repeat (5) begin
      @(negedge clk_40M);
      if (done !== 1'b0) begin
        mismatches++;
        $display("mismatch at %0t ns: row %0d done high before start", $time, r);
      end
    end
    @(posedge clk_40M);
    start <= 1'b1;
    @(posedge clk_40M);
    start <= 1'b0;
    waited = 0;
    @(negedge clk_40M);
    while (done !== 1'b1 && waited < DONE_LIMIT) begin
      @(negedge clk_40M);
      waited++;
    end
    if (done !== 1'b1) begin
      failures++;
      $display("row %0d: done did not rise within %0d cycles of start", r, DONE_LIMIT);
      return;
    end
    for (int a = 0; a < WORDS; a++) begin
      check_host_word(r, a, word_value(seed, a));
    end
    for (int k = 0; k < NUM_LANES; k++) begin
      sum = lane_sum(seed, k);
      if (k == 0 && vectors[r].exp_lane0 != 32'd0) sum = vectors[r].exp_lane0;
      check_host_word(r, int'(ddr_accel_pkg::result_base) + k, {32'h0, sum});
    end
    @(negedge clk_40M);
    if (done_rises - rises_before != 1) begin
      mismatches++;
      $display("mismatch at %0t ns: row %0d done rose %0d times", $time, r,
               done_rises - rises_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk_40M          = 1'b0;
    clk_40MHz_locked = 1'b0;
    start            = 1'b0;
    pattern_seed     = '0;
    host_addr        = '0;
    rnd = lcg_next(32'h7493);
    // lane 0 sums for seeds 0 and 1 worked out by hand
    vectors[0] = '{seed: 16'h0000, exp_lane0: 32'd74416};
    vectors[1] = '{seed: 16'h0001, exp_lane0: 32'd76272};
    vectors[2] = '{seed: 16'h007f, exp_lane0: 32'd0};
    vectors[3] = '{seed: 16'h00ff, exp_lane0: 32'd0};
    vectors[4] = '{seed: rnd[23:8], exp_lane0: 32'd0};
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    $display("run complete: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized from the number of rows
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- ddr_accel.f
design/ddr_accel_pkg.sv
design/mem_model.sv
design/init_loader.sv
design/conv_feeder.sv
design/mac_lane.sv
design/result_writer.sv
design/ddr_accel_top.sv
verification/tb_ddr_accel.sv

//--- Makefile
# Verilator build and run of the accelerator testbench

TOP := tb_ddr_accel

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f ddr_accel.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
